/* verilog/bus_pkg.sv */
`default_nettype none

package bus_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus word and memory geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int word_bits = 32;
  localparam int byte_offset_bits = 2;  // byte lanes within a word.
  localparam int mem_addr_bits = 8;
  localparam int mem_depth = 2 ** mem_addr_bits;  // 256 words, 1 KiB.

  typedef logic [word_bits-1:0] word_t;

  // byte address to word index. bits above the array simply wrap.
  function automatic logic [mem_addr_bits-1:0] word_index(input word_t addr);
    return addr[byte_offset_bits +: mem_addr_bits];
  endfunction

endpackage

`default_nettype wire

/* verilog/isa_pkg.sv */
`default_nettype none

package isa_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // opcodes and function codes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef logic [6:0] opcode_t;

  localparam opcode_t op_imm    = 7'b0010011;  // addi.
  localparam opcode_t op_load   = 7'b0000011;  // lw.
  localparam opcode_t op_store  = 7'b0100011;  // sw.
  localparam opcode_t op_system = 7'b1110011;  // ecall.

  localparam logic [2:0] funct3_addi = 3'd0;
  localparam logic [2:0] funct3_word = 3'd2;

  typedef enum logic [1:0] {
    fault_none       = 2'd0,
    fault_illegal    = 2'd1,
    fault_misaligned = 2'd2
  } fault_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // instruction formats
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_t     opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_t    opcode;
  } s_type_t;

  typedef union packed {
    i_type_t        itype;
    s_type_t        stype;
    bus_pkg::word_t raw;
  } instr_u;

endpackage

`default_nettype wire

/* verilog/reg_file.sv */
`timescale 1ns/10ps
`default_nettype none

module reg_file (
  input  logic           clk,
  input  logic           reset,
  input  logic [4:0]     rs1_sel,
  input  logic [4:0]     rs2_sel,
  input  logic           rd_we,
  input  logic [4:0]     rd_sel,
  input  bus_pkg::word_t rd_data,
  output bus_pkg::word_t rs1_data,
  output bus_pkg::word_t rs2_data
);

  bus_pkg::word_t regs [1:31];  // x0 has no storage.

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_we && rd_sel != 5'd0) begin
      regs[rd_sel] <= rd_data;
    end
  end

  always_comb begin
    rs1_data = '0;
    rs2_data = '0;
    if (rs1_sel != 5'd0) begin
      rs1_data = regs[rs1_sel];
    end
    if (rs2_sel != 5'd0) begin
      rs2_data = regs[rs2_sel];
    end
  end

endmodule

`default_nettype wire

/* verilog/ls_core.sv */
`timescale 1ns/10ps
`default_nettype none

module ls_core (
  input  logic            clk,
  input  logic            reset,
  input  logic            start,
  input  bus_pkg::word_t  start_pc,
  input  bus_pkg::word_t  bus_rdata,
  input  bus_pkg::word_t  rs1_data,
  input  bus_pkg::word_t  rs2_data,
  output logic            bus_read_en,
  output logic            bus_write_en,
  output bus_pkg::word_t  bus_addr,
  output bus_pkg::word_t  bus_wdata,
  output logic [4:0]      rs1_sel,
  output logic [4:0]      rs2_sel,
  output logic            rd_we,
  output logic [4:0]      rd_sel,
  output bus_pkg::word_t  rd_data,
  output logic            busy,
  output logic            done,
  output isa_pkg::fault_t fault,
  output logic [15:0]     retired
);

  typedef enum logic [1:0] {st_idle, st_fetch, st_execute} state_t;

  state_t          state;
  bus_pkg::word_t  pc;
  isa_pkg::instr_u instr;
  bus_pkg::word_t  imm_i;
  bus_pkg::word_t  imm_s;
  bus_pkg::word_t  eff_addr;
  logic            misaligned;
  logic            halt;
  isa_pkg::fault_t halt_fault;
  logic            retire;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // decode and address generation
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign imm_i = {{20{instr.itype.imm[11]}}, instr.itype.imm};
  assign imm_s = {{20{instr.stype.imm_hi[6]}}, instr.stype.imm_hi, instr.stype.imm_lo};

  assign rs1_sel = instr.itype.rs1;  // same bits in both formats.
  assign rs2_sel = instr.stype.rs2;
  assign rd_sel  = instr.itype.rd;

  assign eff_addr   = rs1_data + ((instr.itype.opcode == isa_pkg::op_store) ? imm_s : imm_i);
  assign misaligned = (eff_addr[1:0] != 2'b00);

  assign busy = (state != st_idle);

  always_comb begin
    bus_read_en  = 1'b0;
    bus_write_en = 1'b0;
    bus_addr     = pc;
    bus_wdata    = rs2_data;
    rd_we        = 1'b0;
    rd_data      = eff_addr;  // addi result.
    halt         = 1'b0;
    halt_fault   = isa_pkg::fault_none;
    retire       = 1'b0;
    case (state)
      st_fetch: begin
        bus_read_en = 1'b1;
      end
      st_execute: begin
        case (instr.itype.opcode)
          isa_pkg::op_imm: begin
            if (instr.itype.funct3 == isa_pkg::funct3_addi) begin
              rd_we  = 1'b1;
              retire = 1'b1;
            end else begin
              halt       = 1'b1;
              halt_fault = isa_pkg::fault_illegal;
            end
          end
          isa_pkg::op_load: begin
            if (instr.itype.funct3 != isa_pkg::funct3_word) begin
              halt       = 1'b1;
              halt_fault = isa_pkg::fault_illegal;
            end else if (misaligned) begin
              halt       = 1'b1;
              halt_fault = isa_pkg::fault_misaligned;
            end else begin
              bus_read_en = 1'b1;
              bus_addr    = eff_addr;
              rd_we       = 1'b1;
              rd_data     = bus_rdata;
              retire      = 1'b1;
            end
          end
          isa_pkg::op_store: begin
            if (instr.stype.funct3 != isa_pkg::funct3_word) begin
              halt       = 1'b1;
              halt_fault = isa_pkg::fault_illegal;
            end else if (misaligned) begin
              halt       = 1'b1;
              halt_fault = isa_pkg::fault_misaligned;
            end else begin
              bus_write_en = 1'b1;
              bus_addr     = eff_addr;
              retire       = 1'b1;
            end
          end
          isa_pkg::op_system: begin
            halt = 1'b1;  // ecall, clean stop.
          end
          default: begin
            halt       = 1'b1;
            halt_fault = isa_pkg::fault_illegal;
          end
        endcase
      end
      default: begin
      end
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sequencing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= st_idle;
      pc      <= '0;
      done    <= 1'b0;
      fault   <= isa_pkg::fault_none;
      retired <= '0;
    end else begin
      done <= 1'b0;
      case (state)
        st_idle: begin
          if (start) begin
            state   <= st_fetch;
            pc      <= start_pc;
            fault   <= isa_pkg::fault_none;
            retired <= '0;
          end
        end
        st_fetch: begin
          state <= st_execute;
        end
        st_execute: begin
          if (retire) begin
            retired <= retired + 16'd1;
          end
          if (halt) begin
            state <= st_idle;
            done  <= 1'b1;
            fault <= halt_fault;
          end else begin
            state <= st_fetch;
            pc    <= pc + 32'd4;  // no branches.
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_fetch) begin
      instr <= bus_rdata;
    end
  end

  assert property (@(posedge clk) disable iff (reset) !(bus_write_en && rd_we))
    else $error("ls_core: store and register write in the same cycle");

endmodule

`default_nettype wire

/* verilog/bus_memory.sv */
`timescale 1ns/10ps
`default_nettype none

module bus_memory (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              read_en,
  input  logic                              write_en,
  input  bus_pkg::word_t                    addr,
  input  bus_pkg::word_t                    wdata,
  input  logic                              load_en,
  input  logic [bus_pkg::mem_addr_bits-1:0] load_addr,
  input  bus_pkg::word_t                    load_data,
  input  logic [bus_pkg::mem_addr_bits-1:0] probe_addr,
  input  logic                              clear_count,
  output bus_pkg::word_t                    rdata,
  output bus_pkg::word_t                    probe_data,
  output logic [15:0]                       txn_count
);

  bus_pkg::word_t mem [bus_pkg::mem_depth];

  logic [bus_pkg::mem_addr_bits-1:0] bus_index;

  assign bus_index = bus_pkg::word_index(addr);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // array access
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign rdata      = read_en ? mem[bus_index] : '0;  // zero when idle.
  assign probe_data = mem[probe_addr];                // side port, not counted.

  always_ff @(posedge clk) begin
    if (write_en) begin
      mem[bus_index] <= wdata;
    end else if (load_en) begin
      mem[load_addr] <= load_data;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // transaction counter
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (reset || clear_count) begin
      txn_count <= '0;
    end else if (read_en || write_en) begin
      txn_count <= txn_count + 16'd1;
    end
  end

  assert property (@(posedge clk) disable iff (reset) !(read_en && write_en))
    else $error("bus_memory: read and write strobes together");

  // preload and a core store would both hit the array port.
  assert property (@(posedge clk) disable iff (reset) !(load_en && write_en))
    else $error("bus_memory: preload during a bus write");

endmodule

`default_nettype wire

/* verilog/ls_top.sv */
`timescale 1ns/10ps
`default_nettype none

module ls_top (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              start,
  input  bus_pkg::word_t                    start_pc,
  input  logic                              load_en,
  input  logic [bus_pkg::mem_addr_bits-1:0] load_addr,
  input  bus_pkg::word_t                    load_data,
  input  logic [bus_pkg::mem_addr_bits-1:0] probe_addr,
  output logic                              done,
  output isa_pkg::fault_t                   fault,
  output logic [15:0]                       retired,
  output logic [15:0]                       txn_count,
  output bus_pkg::word_t                    probe_data,
  output logic                              busy
);

  logic           bus_read_en;
  logic           bus_write_en;
  bus_pkg::word_t bus_addr;
  bus_pkg::word_t bus_wdata;
  bus_pkg::word_t bus_rdata;
  logic [4:0]     rs1_sel;
  logic [4:0]     rs2_sel;
  bus_pkg::word_t rs1_data;
  bus_pkg::word_t rs2_data;
  logic           rd_we;
  logic [4:0]     rd_sel;
  bus_pkg::word_t rd_data;

  ls_core core (
    .clk, .reset, .start, .start_pc, .bus_rdata, .rs1_data, .rs2_data,
    .bus_read_en, .bus_write_en, .bus_addr, .bus_wdata, .rs1_sel, .rs2_sel,
    .rd_we, .rd_sel, .rd_data, .busy, .done, .fault, .retired
  );

  reg_file regs (
    .clk, .reset, .rs1_sel, .rs2_sel, .rd_we, .rd_sel, .rd_data, .rs1_data, .rs2_data
  );

  bus_memory mem (
    .clk, .reset, .read_en(bus_read_en), .write_en(bus_write_en), .addr(bus_addr),
    .wdata(bus_wdata), .load_en, .load_addr, .load_data, .probe_addr,
    .clear_count(start), .rdata(bus_rdata), .probe_data, .txn_count
  );

  // program and data are loaded only while the core is stopped.
  assert property (@(posedge clk) disable iff (reset) load_en |-> !busy)
    else $error("ls_top: preload while the core is running");

endmodule

`default_nettype wire

/* tests/clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module clock_gen (
  output logic clk,
  output logic reset
);

  localparam real half_period = 2.0;  // 4 ns clock.
  localparam int reset_cycles = 5;

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;  // released on a falling edge, like all stimulus.
  end

endmodule

`default_nettype wire

/* tests/ls_top_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module ls_top_tb;

  localparam int n_rows = 6;
  localparam int max_prog = 6;
  localparam int max_data = 2;
  localparam int max_probe = 4;
  localparam int cycle_limit = 5 + n_rows * (max_prog + max_data + 2 * max_prog + 20);

  logic                              clk;
  logic                              reset;
  logic                              start;
  bus_pkg::word_t                    start_pc;
  logic                              load_en;
  logic [bus_pkg::mem_addr_bits-1:0] load_addr;
  bus_pkg::word_t                    load_data;
  logic [bus_pkg::mem_addr_bits-1:0] probe_addr;
  logic                              done;
  isa_pkg::fault_t                   fault;
  logic [15:0]                       retired;
  logic [15:0]                       txn_count;
  bus_pkg::word_t                    probe_data;
  logic                              busy;

  // stimulus and expected results, one entry per row.
  isa_pkg::instr_u                   prog [n_rows][max_prog];
  int                                prog_len [n_rows];
  bus_pkg::word_t                    pc_of [n_rows];
  logic [bus_pkg::mem_addr_bits-1:0] data_idx [n_rows][max_data];
  bus_pkg::word_t                    data_val [n_rows][max_data];
  int                                data_len [n_rows];
  logic [bus_pkg::mem_addr_bits-1:0] probe_idx [n_rows][max_probe];
  bus_pkg::word_t                    probe_exp [n_rows][max_probe];
  int                                probe_len [n_rows];
  int                                n_exec [n_rows];  // counts the halting instruction.
  int                                exp_retired [n_rows];
  int                                exp_txn [n_rows];
  isa_pkg::fault_t                   exp_fault [n_rows];

  int checks = 0;
  int errors = 0;
  int cycle_count = 0;

  clock_gen clocks (.clk, .reset);

  ls_top DUT (
    .clk, .reset, .start, .start_pc, .load_en, .load_addr, .load_data, .probe_addr,
    .done, .fault, .retired, .txn_count, .probe_data, .busy
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // encoding and table helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic isa_pkg::instr_u itype_instr(input isa_pkg::opcode_t opcode,
      input logic [2:0] funct3, input logic [4:0] rd, input logic [4:0] rs1,
      input logic [11:0] imm);
    isa_pkg::instr_u w;
    w.itype = '{imm, rs1, funct3, rd, opcode};
    return w;
  endfunction

  function automatic isa_pkg::instr_u stype_instr(input logic [2:0] funct3,
      input logic [4:0] rs2, input logic [4:0] rs1, input logic [11:0] imm);
    isa_pkg::instr_u w;
    w.stype = '{imm[11:5], rs2, rs1, funct3, imm[4:0], isa_pkg::op_store};
    return w;
  endfunction

  // word select is address bits 9..2, higher bits wrap.
  function automatic logic [7:0] index_of(input bus_pkg::word_t addr);
    return addr[9:2];
  endfunction

  task automatic row_setup(input int r, input bus_pkg::word_t pc, input int n,
      input int ret, input int txn, input isa_pkg::fault_t flt);
    pc_of[r] = pc;
    n_exec[r] = n;
    exp_retired[r] = ret;
    exp_txn[r] = txn;
    exp_fault[r] = flt;
  endtask

  task automatic program_append(input int r, input isa_pkg::instr_u w);
    prog[r][prog_len[r]] = w;
    prog_len[r]++;
  endtask

  task automatic preload_entry(input int r, input logic [7:0] idx, input bus_pkg::word_t val);
    data_idx[r][data_len[r]] = idx;
    data_val[r][data_len[r]] = val;
    data_len[r]++;
  endtask

  task automatic probe_expect(input int r, input logic [7:0] idx, input bus_pkg::word_t val);
    probe_idx[r][probe_len[r]] = idx;
    probe_exp[r][probe_len[r]] = val;
    probe_len[r]++;
  endtask

  task automatic build_table();
    bus_pkg::word_t copy_src;
    bus_pkg::word_t wrap_src;
    bus_pkg::word_t x0_src;
    bus_pkg::word_t x0_old;
    bus_pkg::word_t guard;
    copy_src = $urandom;
    wrap_src = $urandom;
    x0_src = $urandom;
    x0_old = $urandom | 32'd1;  // must differ from the zero stored over it.
    guard = $urandom;
    // copy: 4 fetches, one load, one store.
    row_setup(0, 32'h000, 4, 3, 6, isa_pkg::fault_none);
    program_append(0, itype_instr(isa_pkg::op_imm, isa_pkg::funct3_addi, 5'd1, 5'd0, 12'h100));
    program_append(0, itype_instr(isa_pkg::op_load, isa_pkg::funct3_word, 5'd2, 5'd1, 12'h000));
    program_append(0, stype_instr(isa_pkg::funct3_word, 5'd2, 5'd1, 12'h008));
    program_append(0, itype_instr(isa_pkg::op_system, 3'd0, 5'd0, 5'd0, 12'h000));
    preload_entry(0, index_of(32'h100), copy_src);
    probe_expect(0, index_of(32'h108), copy_src);
    probe_expect(0, index_of(32'h100), copy_src);
    // negative offsets, 0x520 - 36 = 0x4fc, and 0x524 beyond 1 KiB.
    row_setup(1, 32'h040, 6, 5, 9, isa_pkg::fault_none);
    program_append(1, itype_instr(isa_pkg::op_imm, isa_pkg::funct3_addi, 5'd3, 5'd0, 12'h150));
    program_append(1, itype_instr(isa_pkg::op_load, isa_pkg::funct3_word, 5'd4, 5'd3, 12'hff0));
    program_append(1, itype_instr(isa_pkg::op_imm, isa_pkg::funct3_addi, 5'd5, 5'd0, 12'h520));
    program_append(1, stype_instr(isa_pkg::funct3_word, 5'd4, 5'd5, 12'hfdc));
    program_append(1, stype_instr(isa_pkg::funct3_word, 5'd4, 5'd5, 12'h004));
    program_append(1, itype_instr(isa_pkg::op_system, 3'd0, 5'd0, 5'd0, 12'h000));
    preload_entry(1, index_of(32'h140), wrap_src);
    probe_expect(1, index_of(32'h4fc), wrap_src);
    probe_expect(1, index_of(32'h524), wrap_src);
    // x0 as load target and as store base.
    row_setup(2, 32'h080, 5, 4, 8, isa_pkg::fault_none);
    program_append(2, itype_instr(isa_pkg::op_imm, isa_pkg::funct3_addi, 5'd6, 5'd0, 12'h168));
    program_append(2, itype_instr(isa_pkg::op_load, isa_pkg::funct3_word, 5'd0, 5'd6, 12'h000));
    program_append(2, stype_instr(isa_pkg::funct3_word, 5'd0, 5'd0, 12'h170));
    program_append(2, stype_instr(isa_pkg::funct3_word, 5'd6, 5'd0, 12'h174));
    program_append(2, itype_instr(isa_pkg::op_system, 3'd0, 5'd0, 5'd0, 12'h000));
    preload_entry(2, index_of(32'h168), x0_src);
    preload_entry(2, index_of(32'h170), x0_old);
    probe_expect(2, index_of(32'h170), 32'h0);
    probe_expect(2, index_of(32'h174), 32'h168);
    probe_expect(2, index_of(32'h168), x0_src);
    // unknown opcode after one addi.
    row_setup(3, 32'h0c0, 2, 1, 2, isa_pkg::fault_illegal);
    program_append(3, itype_instr(isa_pkg::op_imm, isa_pkg::funct3_addi, 5'd7, 5'd0, 12'h005));
    program_append(3, itype_instr(7'h33, 3'd0, 5'd0, 5'd0, 12'h000));
    // lw with funct3 0 is a byte load, not supported.
    row_setup(4, 32'h200, 1, 0, 1, isa_pkg::fault_illegal);
    program_append(4, itype_instr(isa_pkg::op_load, 3'd0, 5'd8, 5'd0, 12'h000));
    program_append(4, itype_instr(isa_pkg::op_system, 3'd0, 5'd0, 5'd0, 12'h000));
    // misaligned store leaves the target word alone.
    row_setup(5, 32'h240, 3, 2, 3, isa_pkg::fault_misaligned);
    program_append(5, itype_instr(isa_pkg::op_imm, isa_pkg::funct3_addi, 5'd9, 5'd0, 12'h190));
    program_append(5, itype_instr(isa_pkg::op_imm, isa_pkg::funct3_addi, 5'd10, 5'd0, 12'h055));
    program_append(5, stype_instr(isa_pkg::funct3_word, 5'd10, 5'd9, 12'h002));
    program_append(5, itype_instr(isa_pkg::op_system, 3'd0, 5'd0, 5'd0, 12'h000));
    preload_entry(5, index_of(32'h190), guard);
    probe_expect(5, index_of(32'h190), guard);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks and row sequencing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic compare(input string what, input int row, input bus_pkg::word_t got,
      input bus_pkg::word_t expected);
    checks++;
    assert (got == expected)
      else begin
        errors++;
        $display("[FAIL] %0d ns row %0d %s: got %h, expected %h", $time, row, what, got,
                 expected);
      end
  endtask

  task automatic preload_row(input int r);
    int i;
    for (i = 0; i < prog_len[r]; i++) begin
      @(negedge clk);
      load_en = 1'b1;
      load_addr = index_of(pc_of[r] + 32'(4 * i));
      load_data = prog[r][i].raw;
    end
    for (i = 0; i < data_len[r]; i++) begin
      @(negedge clk);
      load_en = 1'b1;
      load_addr = data_idx[r][i];
      load_data = data_val[r][i];
    end
    @(negedge clk);
    load_en = 1'b0;
  endtask

  task automatic run_row(input int r);
    int cycles;
    int p;
    @(negedge clk);
    start = 1'b1;
    start_pc = pc_of[r];
    @(negedge clk);
    start = 1'b0;
    cycles = 1;
    while (done !== 1'b1) begin
      compare("busy while running", r, 32'(busy), 32'd1);
      @(negedge clk);
      cycles++;
    end
    compare("start to done cycles", r, cycles, 2 * n_exec[r] + 1);
    compare("busy at done", r, 32'(busy), 32'd0);
    compare("fault", r, 32'(fault), 32'(exp_fault[r]));
    compare("retired", r, 32'(retired), exp_retired[r]);
    compare("txn_count", r, 32'(txn_count), exp_txn[r]);
    @(negedge clk);
    compare("done still high", r, 32'(done), 32'd0);  // single-cycle pulse.
    for (p = 0; p < probe_len[r]; p++) begin
      probe_addr = probe_idx[r][p];
      @(posedge clk);
      compare("probe word", r, probe_data, probe_exp[r][p]);
      @(negedge clk);
    end
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == cycle_limit) begin
      $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial begin
    int r;
    start = 1'b0;
    start_pc = '0;
    load_en = 1'b0;
    load_addr = '0;
    load_data = '0;
    probe_addr = '0;
    void'($urandom(20));
    build_table();
    wait (reset == 1'b0);
    @(negedge clk);
    compare("done after reset", -1, 32'(done), 32'd0);
    for (r = 0; r < n_rows; r++) begin
      preload_row(r);
      run_row(r);
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
verilog/bus_pkg.sv
verilog/isa_pkg.sv
verilog/reg_file.sv
verilog/ls_core.sv
verilog/bus_memory.sv
verilog/ls_top.sv
tests/clock_gen.sv
tests/ls_top_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module ls_top_tb -f compile.f -Mdir obj_dir -o ls_top_sim

output=$(./obj_dir/ls_top_sim 2>&1)
echo "$output"

if echo "$output" | grep -qx "NO ERRORS"; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
